// File: hdl/chol_pkg.sv
/*
 * Shared sizes, bus address map, sequencer states and the handoff records of the
 * Cholesky engine. Every RTL file refers to these by scoped names.
 */
package chol_pkg;

	localparam int MAT_N      = 4; // Rows and columns of the matrix
	localparam int IDX_W      = 2; // Enough bits to index one row or column
	localparam int DATA_W     = 24; // Signed fixed-point word held in the store
	localparam int FRAC_W     = 8; // Values are integers scaled by 256
	localparam int WB_ADR_W   = 6; // Word address
	localparam int WB_DAT_W   = 32;
	localparam int ADR_A_BASE = 0; // A(r,c) sits at base + r*MAT_N + c
	localparam int ADR_L_BASE = 16; // L uses the same layout
	localparam int ADR_CTRL   = 32; // Control on write, status on read
	localparam int SQRT_ITERS = 16; // One result bit per bit pair of a 32 bit radicand
	localparam int DIV_ITERS  = 32; // One quotient bit per cycle

	typedef logic signed [DATA_W-1:0] fix_t;
	typedef fix_t [MAT_N-1:0][MAT_N-1:0] matrix_t; // Indexed [row][col]

	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                ack;
		logic [WB_DAT_W-1:0] dat;
	} wb_rsp_t;

	typedef enum logic [2:0] {
		IDLE, SQRT, DIV_UPD, DRAIN, DONE, FAIL
	} seq_state_e;

	typedef struct packed {
		logic [IDX_W-1:0] col;
		fix_t             radical; // Updated diagonal A'_jj
	} sqrt_job_t;

	typedef struct packed {
		logic valid; // One cycle pulse per finished job
		logic fail; // Radical was zero or negative
	} sqrt_res_t;

	typedef struct packed {
		logic [IDX_W-1:0] row;
		logic [IDX_W-1:0] col;
		fix_t             dividend; // A'_ij
		fix_t             divisor; // L_jj, always positive
	} div_job_t;

	typedef struct packed {
		logic [IDX_W-1:0] row;
		logic [IDX_W-1:0] col;
		fix_t             lij;
	} upd_job_t;

	typedef struct packed {
		logic             valid;
		logic [IDX_W-1:0] row;
		logic [IDX_W-1:0] col;
		fix_t             value;
	} elem_wr_t;

endpackage

// File: hdl/chol_wb_slave.sv
/*
 * Wishbone classic slave of the engine. Decodes A, L and the control word,
 * produces the one cycle ack and keeps the status bits and the irq level.
 */
`timescale 1ns/1ns

module chol_wb_slave (
	input  logic                i,
	input  logic                rst_n,
	input  chol_pkg::wb_req_t   wb_req,
	output chol_pkg::wb_rsp_t   wb_rsp,
	output logic                irq,
	output chol_pkg::elem_wr_t  load_wr,
	output logic                start,
	input  chol_pkg::matrix_t   l_mat,
	input  logic                busy,
	input  logic                done,
	input  logic                fail
);

	logic req; // New access this cycle
	logic done_r, not_pd_r;
	logic [chol_pkg::IDX_W-1:0] row, col;
	logic is_a, is_l, is_ctrl;

	assign req     = wb_req.cyc && wb_req.stb && !wb_rsp.ack; // Ack drops the held strobe
	assign row     = wb_req.adr[2*chol_pkg::IDX_W-1:chol_pkg::IDX_W];
	assign col     = wb_req.adr[chol_pkg::IDX_W-1:0];
	assign is_a    = wb_req.adr[5:4] == 2'(chol_pkg::ADR_A_BASE >> 4);
	assign is_l    = wb_req.adr[5:4] == 2'(chol_pkg::ADR_L_BASE >> 4);
	assign is_ctrl = wb_req.adr == chol_pkg::WB_ADR_W'(chol_pkg::ADR_CTRL);

	always_ff @(posedge i) begin
		if (!rst_n) begin
			wb_rsp.ack    <= 1'b0;
			load_wr.valid <= 1'b0;
			start         <= 1'b0;
		end else begin
			wb_rsp.ack    <= req;
			load_wr.valid <= req && wb_req.we && is_a && !busy; // Loads ignored while running
			start         <= req && wb_req.we && is_ctrl && wb_req.dat[0] && !busy;
		end
	end

	always_ff @(posedge i) begin
		load_wr.row   <= row;
		load_wr.col   <= col;
		load_wr.value <= wb_req.dat[chol_pkg::DATA_W-1:0];
		wb_rsp.dat    <= '0; // A reads back as zero
		if (is_l && col <= row)
			wb_rsp.dat <= chol_pkg::WB_DAT_W'(l_mat[row][col]); // Sign extends the element
		else if (is_ctrl)
			wb_rsp.dat <= {29'b0, not_pd_r, done_r, busy};
	end

	always_ff @(posedge i) begin
		if (!rst_n) begin
			done_r   <= 1'b0;
			not_pd_r <= 1'b0;
			irq      <= 1'b0;
		end else if (start) begin // The sequencer leaves DONE or FAIL on this edge
			done_r   <= 1'b0;
			not_pd_r <= 1'b0;
			irq      <= 1'b0;
		end else begin
			done_r   <= done_r || done;
			not_pd_r <= not_pd_r || fail;
			irq      <= irq || done || fail; // Level until the next start
		end
	end

	// A' only takes host loads while the sequencer is idle
	load_lands_idle: assert property (@(posedge i) disable iff (!rst_n)
		load_wr.valid |-> !busy);

endmodule

// File: hdl/chol_matrix_store.sv
/*
 * Register store for the working matrix A' and the result L. A' takes host loads
 * and update results, L takes square roots and quotients and clears on start.
 */
`timescale 1ns/1ns

module chol_matrix_store (
	input  logic               i,
	input  logic               rst_n,
	input  chol_pkg::elem_wr_t load_wr,
	input  logic               clear_l,
	input  chol_pkg::elem_wr_t sqrt_wr,
	input  chol_pkg::elem_wr_t div_wr,
	input  chol_pkg::elem_wr_t upd_wr,
	output chol_pkg::matrix_t  a_mat,
	output chol_pkg::matrix_t  l_mat
);

	// Loads only land while idle and updates only while busy, so they never meet
	always_ff @(posedge i) begin
		if (load_wr.valid)
			a_mat[load_wr.row][load_wr.col] <= load_wr.value;
		if (upd_wr.valid)
			a_mat[upd_wr.row][upd_wr.col] <= upd_wr.value;
	end

	always_ff @(posedge i) begin
		if (!rst_n || clear_l) begin
			l_mat <= '0; // Upper triangle stays zero for good
		end else begin
			if (sqrt_wr.valid)
				l_mat[sqrt_wr.row][sqrt_wr.col] <= sqrt_wr.value; // Diagonal
			if (div_wr.valid)
				l_mat[div_wr.row][div_wr.col] <= div_wr.value; // Below the diagonal
		end
	end

	// The two L producers must never collide on one element
	l_wr_disjoint: assert property (@(posedge i) disable iff (!rst_n)
		(sqrt_wr.valid && div_wr.valid) |->
		(sqrt_wr.row != div_wr.row || sqrt_wr.col != div_wr.col));

	// A finished divide never overwrites a diagonal that a square root owns
	div_below_diag: assert property (@(posedge i) disable iff (!rst_n)
		div_wr.valid |-> div_wr.row > div_wr.col);

endmodule

// File: hdl/chol_sequencer.sv
/*
 * Column sequencer. For each column it issues one square root, then one divide
 * per lower row, and drains the update pipe before stepping to the next column.
 */
`timescale 1ns/1ns

module chol_sequencer (
	input  logic                 i,
	input  logic                 rst_n,
	input  logic                 start,
	input  chol_pkg::matrix_t    a_mat,
	input  chol_pkg::matrix_t    l_mat,
	output chol_pkg::sqrt_job_t  sqrt_job,
	output logic                 sqrt_valid,
	input  logic                 sqrt_ready,
	input  chol_pkg::sqrt_res_t  sqrt_res,
	output chol_pkg::div_job_t   div_job,
	output logic                 div_valid,
	input  logic                 div_ready,
	input  logic                 upd_idle,
	output logic                 clear_l,
	output logic                 busy,
	output logic                 done,
	output logic                 fail
);

	chol_pkg::seq_state_e state;
	logic [chol_pkg::IDX_W-1:0] col, row;
	logic sqrt_sent; // Radical of this column already handed over

	localparam logic [chol_pkg::IDX_W-1:0] LAST = chol_pkg::IDX_W'(chol_pkg::MAT_N - 1);

	assign sqrt_valid       = state == chol_pkg::SQRT && !sqrt_sent;
	assign sqrt_job.col     = col;
	assign sqrt_job.radical = a_mat[col][col];
	assign div_valid        = state == chol_pkg::DIV_UPD;
	assign div_job.row      = row;
	assign div_job.col      = col;
	assign div_job.dividend = a_mat[row][col];
	assign div_job.divisor  = l_mat[col][col]; // Written the edge we entered DIV_UPD
	assign busy = state inside {chol_pkg::SQRT, chol_pkg::DIV_UPD, chol_pkg::DRAIN};
	assign done = state == chol_pkg::DONE;
	assign fail = state == chol_pkg::FAIL;
	assign clear_l = start && !busy;

	always_ff @(posedge i) begin
		if (!rst_n) begin
			state     <= chol_pkg::IDLE;
			col       <= '0;
			row       <= '0;
			sqrt_sent <= 1'b0;
		end else begin
			case (state)
				chol_pkg::IDLE, chol_pkg::DONE, chol_pkg::FAIL: begin
					if (start) begin
						state     <= chol_pkg::SQRT;
						col       <= '0;
						sqrt_sent <= 1'b0;
					end
				end
				chol_pkg::SQRT: begin
					if (sqrt_valid && sqrt_ready)
						sqrt_sent <= 1'b1;
					if (sqrt_res.valid) begin
						if (sqrt_res.fail)
							state <= chol_pkg::FAIL; // Not positive definite
						else if (col == LAST)
							state <= chol_pkg::DONE; // Last column has no rows below
						else begin
							state <= chol_pkg::DIV_UPD;
							row   <= col + 1'b1;
						end
					end
				end
				chol_pkg::DIV_UPD: begin
					if (div_ready) begin
						if (row == LAST)
							state <= chol_pkg::DRAIN;
						else
							row <= row + 1'b1;
					end
				end
				chol_pkg::DRAIN: begin
					if (div_ready && upd_idle) begin // Quotients and updates all landed
						state     <= chol_pkg::SQRT;
						col       <= col + 1'b1;
						sqrt_sent <= 1'b0;
					end
				end
				default: state <= chol_pkg::IDLE;
			endcase
		end
	end

	// A root only comes back for a radical this column has handed over
	sqrt_res_expected: assert property (@(posedge i) disable iff (!rst_n)
		sqrt_res.valid |-> (state == chol_pkg::SQRT && sqrt_sent));

endmodule

// File: hdl/chol_sqrt_stage.sv
/*
 * Square root of the diagonal, two radicand bits per cycle. Writes
 * floor(sqrt(A'_jj*256)) into L_jj, or reports failure for a radical <= 0.
 */
`timescale 1ns/1ns

module chol_sqrt_stage (
	input  logic                 i,
	input  logic                 rst_n,
	input  chol_pkg::sqrt_job_t  job,
	input  logic                 job_valid,
	output logic                 ready,
	output chol_pkg::sqrt_res_t  res,
	output chol_pkg::elem_wr_t   l_wr
);

	logic        busy, fin;
	logic [4:0]  cnt;
	logic [31:0] rad; // Remaining radicand bits, consumed from the top
	logic [17:0] rem;
	logic [15:0] root;
	logic [chol_pkg::IDX_W-1:0] col;
	logic [17:0] rem_sh, trial;

	assign ready  = !busy && !fin;
	assign rem_sh = {rem[15:0], rad[31:30]};
	assign trial  = {root, 2'b01}; // 4*root + 1

	always_ff @(posedge i) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			fin       <= 1'b0;
			res       <= '0;
			l_wr.valid <= 1'b0;
		end else begin
			res        <= '0;
			l_wr.valid <= 1'b0;
			fin        <= 1'b0;
			if (job_valid && ready) begin
				if (job.radical <= 0)
					res <= '{valid: 1'b1, fail: 1'b1}; // Nothing is computed
				else
					busy <= 1'b1;
			end else if (busy && cnt == 5'(chol_pkg::SQRT_ITERS - 1)) begin
				busy <= 1'b0;
				fin  <= 1'b1;
			end else if (fin) begin
				res        <= '{valid: 1'b1, fail: 1'b0};
				l_wr.valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge i) begin
		if (job_valid && ready) begin
			rad  <= {job.radical, 8'b0}; // Times 256
			rem  <= '0;
			root <= '0;
			cnt  <= '0;
			col  <= job.col;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			rad <= rad << 2;
			if (rem_sh >= trial) begin
				rem  <= rem_sh - trial;
				root <= {root[14:0], 1'b1};
			end else begin
				rem  <= rem_sh;
				root <= {root[14:0], 1'b0};
			end
		end
		l_wr.row   <= col;
		l_wr.col   <= col;
		l_wr.value <= chol_pkg::DATA_W'(root); // Positive, zero extended
	end

endmodule

// File: hdl/chol_div_stage.sv
/*
 * Restoring divider for the off-diagonal elements. Computes A'_ij*256 / L_jj
 * truncated toward zero, writes L_ij and offers it to the update stage.
 */
`timescale 1ns/1ns

module chol_div_stage (
	input  logic                i,
	input  logic                rst_n,
	input  chol_pkg::div_job_t  job,
	input  logic                job_valid,
	output logic                ready,
	output chol_pkg::elem_wr_t  l_wr,
	output chol_pkg::upd_job_t  upd,
	output logic                upd_valid,
	input  logic                upd_ready
);

	logic        busy, fin;
	logic [5:0]  cnt;
	logic [31:0] quo; // Dividend magnitude shifts out as quotient bits shift in
	logic [24:0] rem;
	logic [23:0] dvs;
	logic        neg;
	logic [chol_pkg::IDX_W-1:0] row, col;
	logic signed [31:0] num;
	logic [24:0] rem_sh;
	logic [31:0] quo_s;

	assign ready  = !busy && !fin && !upd_valid; // Held result blocks new work
	assign num    = {job.dividend, 8'b0};
	assign rem_sh = {rem[23:0], quo[31]};
	assign quo_s  = neg ? -quo : quo;

	always_ff @(posedge i) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			fin        <= 1'b0;
			l_wr.valid <= 1'b0;
			upd_valid  <= 1'b0;
		end else begin
			l_wr.valid <= 1'b0;
			fin        <= 1'b0;
			if (job_valid && ready)
				busy <= 1'b1;
			else if (busy && cnt == 6'(chol_pkg::DIV_ITERS - 1)) begin
				busy <= 1'b0;
				fin  <= 1'b1;
			end else if (fin) begin
				l_wr.valid <= 1'b1;
				upd_valid  <= 1'b1; // Same edge as the write into L
			end else if (upd_valid && upd_ready)
				upd_valid <= 1'b0;
		end
	end

	always_ff @(posedge i) begin
		if (job_valid && ready) begin
			quo <= num < 0 ? 32'(-num) : 32'(num);
			neg <= num < 0;
			dvs <= job.divisor;
			rem <= '0;
			cnt <= '0;
			row <= job.row;
			col <= job.col;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (rem_sh >= {1'b0, dvs}) begin
				rem <= rem_sh - {1'b0, dvs};
				quo <= {quo[30:0], 1'b1};
			end else begin
				rem <= rem_sh;
				quo <= {quo[30:0], 1'b0};
			end
		end
		if (fin) begin
			l_wr.row   <= row;
			l_wr.col   <= col;
			l_wr.value <= quo_s[chol_pkg::DATA_W-1:0]; // Wraps to the store width
			upd.row    <= row;
			upd.col    <= col;
			upd.lij    <= quo_s[chol_pkg::DATA_W-1:0];
		end
	end

	// The sequencer only divides by a finished, positive diagonal
	divisor_pos: assert property (@(posedge i) disable iff (!rst_n)
		(job_valid && ready) |-> job.divisor > 0);

endmodule

// File: hdl/chol_update_stage.sv
/*
 * Update unit. For one new L_ij it walks k = j+1..i and writes
 * A'_ik - (L_ij*L_kj >>> 8), one element per cycle through a registered multiply.
 */
`timescale 1ns/1ns

module chol_update_stage (
	input  logic                i,
	input  logic                rst_n,
	input  chol_pkg::upd_job_t  job,
	input  logic                job_valid,
	output logic                ready,
	input  chol_pkg::matrix_t   l_mat,
	input  chol_pkg::matrix_t   a_mat,
	output chol_pkg::elem_wr_t  a_wr,
	output logic                idle
);

	logic busy;
	chol_pkg::upd_job_t cur;
	logic [chol_pkg::IDX_W-1:0] k;
	logic signed [2*chol_pkg::DATA_W-1:0] prod;
	logic p_valid;
	logic [chol_pkg::IDX_W-1:0] p_row, p_col;
	chol_pkg::fix_t l_kj;
	logic signed [2*chol_pkg::DATA_W-1:0] prod_sh;

	assign ready   = !busy;
	assign idle    = !busy && !p_valid && !a_wr.valid; // Last write has reached A'
	assign l_kj    = l_mat[k][cur.col]; // L_ij lands in the store on the accept edge
	assign prod_sh = prod >>> chol_pkg::FRAC_W;

	always_ff @(posedge i) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			p_valid    <= 1'b0;
			a_wr.valid <= 1'b0;
		end else begin
			p_valid    <= busy;
			a_wr.valid <= p_valid;
			if (job_valid && ready)
				busy <= 1'b1;
			else if (busy && k == cur.row)
				busy <= 1'b0; // Row i reached
		end
	end

	always_ff @(posedge i) begin
		if (job_valid && ready) begin
			cur <= job;
			k   <= job.col + 1'b1;
		end else if (busy)
			k <= k + 1'b1;
		prod  <= cur.lij * l_kj; // Multiply stage
		p_row <= cur.row;
		p_col <= k;
		a_wr.row   <= p_row; // Subtract stage
		a_wr.col   <= p_col;
		a_wr.value <= a_mat[p_row][p_col] - prod_sh[chol_pkg::DATA_W-1:0];
	end

endmodule

// File: hdl/chol_top.sv
/*
 * Top of the Cholesky engine. A host loads A and reads L over Wishbone, the
 * sequencer walks the columns and the three stages do the arithmetic.
 */
`timescale 1ns/1ns

module chol_top (
	input  logic               i,
	input  logic               rst_n,
	input  chol_pkg::wb_req_t  wb_req,
	output chol_pkg::wb_rsp_t  wb_rsp,
	output logic               irq
);

	chol_pkg::elem_wr_t  load_wr, sqrt_wr, div_wr, upd_wr; // Store write ports
	chol_pkg::matrix_t   a_mat, l_mat;
	chol_pkg::sqrt_job_t sqrt_job;
	chol_pkg::sqrt_res_t sqrt_res;
	chol_pkg::div_job_t  div_job;
	chol_pkg::upd_job_t  upd_job;
	logic start, clear_l, busy, done, fail;
	logic sqrt_valid, sqrt_ready, div_valid, div_ready;
	logic upd_valid, upd_ready, upd_idle;

	chol_wb_slave i_wb (.i, .rst_n, .wb_req, .wb_rsp, .irq, .load_wr, .start,
		.l_mat, .busy, .done, .fail);

	chol_matrix_store i_store (.i, .rst_n, .load_wr, .clear_l, .sqrt_wr, .div_wr,
		.upd_wr, .a_mat, .l_mat);

	chol_sequencer i_seq (.i, .rst_n, .start, .a_mat, .l_mat, .sqrt_job, .sqrt_valid,
		.sqrt_ready, .sqrt_res, .div_job, .div_valid, .div_ready, .upd_idle, .clear_l,
		.busy, .done, .fail);

	chol_sqrt_stage i_sqrt (.i, .rst_n, .job(sqrt_job), .job_valid(sqrt_valid),
		.ready(sqrt_ready), .res(sqrt_res), .l_wr(sqrt_wr));

	chol_div_stage i_div (.i, .rst_n, .job(div_job), .job_valid(div_valid),
		.ready(div_ready), .l_wr(div_wr), .upd(upd_job), .upd_valid, .upd_ready);

	chol_update_stage i_upd (.i, .rst_n, .job(upd_job), .job_valid(upd_valid),
		.ready(upd_ready), .l_mat, .a_mat, .a_wr(upd_wr), .idle(upd_idle));

endmodule

// File: testbench/chol_tb.sv
/*
 * Testbench for the Cholesky engine. Loads matrices over Wishbone, starts each run,
 * polls the status until it ends and compares irq, status and every element of L
 * with an integer model.
 */
`timescale 1ns/1ns

module chol_tb;

	localparam int N         = chol_pkg::MAT_N;
	localparam int SCALE     = 1 << chol_pkg::FRAC_W; // One unit in raw fixed point
	localparam int ACK_LIMIT = 16; // Cycles allowed for a single bus ack
	localparam int RUN_LIMIT = 4000; // Status polls allowed for one decomposition

	logic i;
	logic rst_n;
	chol_pkg::wb_req_t wb_req;
	chol_pkg::wb_rsp_t wb_rsp;
	logic irq;

	int seed;
	int checks;
	int errors;
	longint a_in[N][N]; // Matrix loaded into the DUT, raw values
	longint exp_l[N][N]; // Model result, zero where nothing is computed
	bit exp_fail;
	logic [31:0] rd;

	chol_top i_dut (.i, .rst_n, .wb_req, .wb_rsp, .irq);

	always #5 i = ~i; // 10 ns period

	// Every ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge i) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
	else begin
		errors++;
		$display("Ack stayed high for more than one cycle at %0t ns", $time);
	end

	// A start drops irq on the same edge where the engine turns busy
	irq_not_busy: assert property (@(posedge i) disable iff (!rst_n)
		!(irq && i_dut.busy))
	else begin
		errors++;
		$display("Interrupt was high while the engine was busy at %0t ns", $time);
	end

	function automatic longint wrap24(longint v);
		logic signed [chol_pkg::DATA_W-1:0] w;
		w = v[chol_pkg::DATA_W-1:0];
		return w; // Sign extends back to 64 bits
	endfunction

	function automatic longint isqrt(longint v);
		longint r;
		r = 0;
		while ((r + 1) * (r + 1) <= v)
			r++;
		return r; // Floor of the root
	endfunction

	// Column by column: root of the diagonal, quotients below it, then the updates
	function automatic void model_cholesky();
		longint a[N][N];
		longint l[N][N];
		bit fail;
		a = a_in;
		fail = 1'b0;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				l[r][c] = 0;
		for (int j = 0; j < N && !fail; j++) begin
			if (a[j][j] <= 0) begin
				fail = 1'b1; // Run stops, later columns stay cleared
			end else begin
				l[j][j] = wrap24(isqrt(a[j][j] * SCALE));
				for (int r = j + 1; r < N; r++) begin
					l[r][j] = wrap24((a[r][j] * SCALE) / l[j][j]); // Truncates toward zero
					for (int k = j + 1; k <= r; k++)
						a[r][k] = wrap24(a[r][k] - wrap24((l[r][j] * l[k][j]) >>> chol_pkg::FRAC_W));
				end
			end
		end
		exp_l = l;
		exp_fail = fail;
	endfunction

	// M*M' + 8*I with entries of M in -3..3 is positive definite
	function automatic void make_spd();
		int m[N][N];
		int s;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				m[r][c] = $random(seed) % 4;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				s = (r == c) ? 8 : 0;
				for (int k = 0; k < N; k++)
					s += m[r][k] * m[c][k];
				a_in[r][c] = s * SCALE;
			end
		end
	endfunction

	task automatic stop_on_timeout(input string what);
		errors++;
		$display("%s at %0t ns", what, $time);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(posedge i);
			#1;
			n++;
		end while (!wb_rsp.ack && n < ACK_LIMIT);
		if (!wb_rsp.ack)
			stop_on_timeout("No Wishbone ack arrived within the cycle limit");
	endtask

	task automatic write_reg(input int adr, input logic [31:0] dat);
		@(posedge i);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b1;
		wb_req.adr = chol_pkg::WB_ADR_W'(adr);
		wb_req.dat = dat;
		wait_ack();
		wb_req.cyc = 1'b0; // Cycle ends right after the ack
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	task automatic read_reg(input int adr, output logic [31:0] dat);
		@(posedge i);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b0;
		wb_req.adr = chol_pkg::WB_ADR_W'(adr);
		wait_ack();
		dat = wb_rsp.dat; // Valid while ack is high
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	// Busy is status bit 0
	task automatic wait_idle();
		logic [31:0] d;
		int n;
		n = 0;
		do begin
			read_reg(chol_pkg::ADR_CTRL, d);
			n++;
		end while (d[0] && n < RUN_LIMIT);
		if (d[0])
			stop_on_timeout("Engine was still busy after the status poll limit");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp)
		else begin
			errors++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic load_matrix();
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				write_reg(chol_pkg::ADR_A_BASE + r * N + c, 32'(a_in[r][c]));
	endtask

	// Upper triangle reads as zero, lower elements are sign extended
	task automatic check_l();
		logic [31:0] d;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				read_reg(chol_pkg::ADR_L_BASE + r * N + c, d);
				check_eq($sformatf("L[%0d][%0d]", r, c), d, (c <= r) ? 32'(exp_l[r][c]) : 32'h0);
			end
		end
	endtask

	task automatic finish_and_check();
		logic [31:0] d;
		wait_idle();
		check_eq("irq", 32'(irq), 32'h1);
		read_reg(chol_pkg::ADR_CTRL, d);
		check_eq("status", d, exp_fail ? 32'h4 : 32'h2); // not_pd or done, never busy
		check_l();
	endtask

	task automatic run_matrix();
		model_cholesky();
		load_matrix();
		write_reg(chol_pkg::ADR_CTRL, 32'h1);
		finish_and_check();
	endtask

	initial begin
		i      = 1'b0;
		rst_n  = 1'b0;
		wb_req = '0;
		seed   = 32'h7616;
		checks = 0;
		errors = 0;
		repeat (5) @(posedge i);
		#1;
		rst_n = 1'b1;

		check_eq("irq", 32'(irq), 32'h0); // Quiet after reset
		check_eq("ack", 32'(wb_rsp.ack), 32'h0);
		read_reg(chol_pkg::ADR_CTRL, rd);
		check_eq("status", rd, 32'h0);

		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				a_in[r][c] = (r == c) ? 4 * SCALE : 0; // 4.0 times identity
		run_matrix();
		read_reg(chol_pkg::ADR_L_BASE, rd);
		check_eq("L[0][0]", rd, 32'h200); // Root of 4.0 is 2.0

		repeat (3) begin
			make_spd();
			run_matrix();
		end

		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				a_in[r][c] = 0;
		a_in[0][0] = 4 * SCALE;
		a_in[1][1] = 4 * SCALE;
		a_in[3][3] = 4 * SCALE;
		a_in[2][0] = 4 * SCALE; // L20 = 2.0 drives A'22 from 1.0 down to -3.0
		a_in[0][2] = 4 * SCALE;
		a_in[2][2] = 1 * SCALE;
		run_matrix();

		make_spd();
		model_cholesky();
		load_matrix();
		write_reg(chol_pkg::ADR_CTRL, 32'h1);
		write_reg(chol_pkg::ADR_A_BASE + 2 * N + 2, 32'h1); // Would corrupt A'22 if taken
		write_reg(chol_pkg::ADR_CTRL, 32'h1); // Second start while busy
		finish_and_check();

		load_matrix(); // A' was consumed by the last run
		write_reg(chol_pkg::ADR_CTRL, 32'h1);
		read_reg(chol_pkg::ADR_CTRL, rd);
		check_eq("status", rd, 32'h1); // Busy only, done cleared
		check_eq("irq", 32'(irq), 32'h0);
		read_reg(chol_pkg::ADR_L_BASE + 3 * N, rd);
		check_eq("L[3][0]", rd, 32'h0); // Cleared by the start
		finish_and_check();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: sim.f
hdl/chol_pkg.sv
hdl/chol_wb_slave.sv
hdl/chol_matrix_store.sv
hdl/chol_sequencer.sv
hdl/chol_sqrt_stage.sv
hdl/chol_div_stage.sv
hdl/chol_update_stage.sv
hdl/chol_top.sv
testbench/chol_tb.sv

// File: Makefile
# Verilator flow for the Cholesky engine testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module chol_tb -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module chol_tb -Mdir obj_dir -f sim.f
	./obj_dir/Vchol_tb | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
